// File: verilog/corr_data_pkg.sv
`default_nettype none

package corr_data_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sample format
   ////////////////////////////////////////////////////////////////////////////

   // width of one real or imaginary part, top level may override
   localparam int DATA_WIDTH = 8;

   // complex sample, real part high, imaginary part low
   typedef logic [2*DATA_WIDTH-1:0] sample_t;

   ////////////////////////////////////////////////////////////////////////////
   // product and accumulator widths
   ////////////////////////////////////////////////////////////////////////////

   // one part of a complex product
   // sum or difference of two full products, one bit of growth
   function automatic int prod_w(input int data_w);
      return 2 * data_w + 1;
   endfunction

   // one part of a lane accumulator, one pass of reg_num products
   // complex accumulator word is two of these, real over imaginary
   function automatic int acc_w(input int data_w, input int reg_num);
      return prod_w(data_w) + $clog2(reg_num);
   endfunction

endpackage

`default_nettype wire

// File: verilog/corr_seq_pkg.sv
`default_nettype none

package corr_seq_pkg;

   // ring sequencer
   // WAIT  loaded, no step yet in this pass
   // SHIFT at least one step taken in this pass
   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      WAIT,
      SHIFT
   } seq_state_t;

   // step within one pass
   typedef logic [7:0] step_cnt_t;
   // pass within one Y block
   typedef logic [7:0] pass_cnt_t;
   // Y words stored so far, whole ring
   typedef logic [12:0] load_cnt_t;

endpackage

`default_nettype wire

// File: verilog/ring_if.sv
`timescale 1ns/10ps
`default_nettype none

// taps and broadcast X word from the Y ring to the MAC lanes
interface ring_if #(
   parameter int PE_NUM = 4
) ();
   import corr_data_pkg::*;

   // segment tail samples, lane i reads tap[i]
   sample_t tap [PE_NUM];
   // X word shared by all lanes
   sample_t x;
   // one pulse per accepted X word
   logic    step;
   // pass markers, only together with step
   logic    first;
   logic    last;

   modport src (
      output tap, x, step, first, last
   );

   modport snk (
      input tap, x, step, first, last
   );

endinterface

`default_nettype wire

// File: verilog/sipo_y.sv
`timescale 1ns/10ps
`default_nettype none

module sipo_y #(
   parameter int PE_NUM   = 4,
   parameter int REG_NUM  = 8,
   parameter int ITER_NUM = 4
) (
   input  logic                   clk,
   input  logic                   rst,
   input  corr_data_pkg::sample_t y_in,
   input  logic                   y_in_v,
   input  corr_data_pkg::sample_t x_in,
   input  logic                   x_in_v,
   output logic                   busy,
   ring_if.src                    ring
);
   import corr_data_pkg::*;
   import corr_seq_pkg::*;

   localparam int RING_LEN = PE_NUM * REG_NUM;

   seq_state_t state;
   load_cnt_t  load_cnt;
   step_cnt_t  step_cnt;
   pass_cnt_t  pass_cnt;

   // ring of PE_NUM segments, [0] head, [REG_NUM-1] tail
   sample_t    seg [PE_NUM][REG_NUM];
   sample_t    ring_din;

   logic       load_en;
   logic       rot_en;
   logic       load_last;
   logic       pass_end;
   logic       iter_end;

   ////////////////////////////////////////////////////////////////////////////
   // accept rules
   ////////////////////////////////////////////////////////////////////////////

   // Y only while loading, X only once the ring is full
   assign load_en   = y_in_v && (state == IDLE || state == LOAD);
   assign rot_en    = x_in_v && (state == WAIT || state == SHIFT);

   assign load_last = load_cnt == load_cnt_t'(RING_LEN - 1);
   assign pass_end  = step_cnt == step_cnt_t'(REG_NUM - 1);
   assign iter_end  = pass_cnt == pass_cnt_t'(ITER_NUM - 1);

   // head input: new Y word, or the ring tail fed back
   assign ring_din  = load_en ? y_in : seg[PE_NUM-1][REG_NUM-1];

   ////////////////////////////////////////////////////////////////////////////
   // ring storage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (load_en || rot_en) begin
         seg[0][0] <= ring_din;
         // each segment head takes the previous segment tail
         for (int j = 1; j < PE_NUM; j++) begin
            seg[j][0] <= seg[j-1][REG_NUM-1];
         end
         for (int j = 0; j < PE_NUM; j++) begin
            for (int k = 1; k < REG_NUM; k++) begin
               seg[j][k] <= seg[j][k-1];
            end
         end
      end
   end

   // taps sampled before this step's rotation lands
   always_ff @(posedge clk) begin
      if (rot_en) begin
         for (int j = 0; j < PE_NUM; j++) begin
            ring.tap[j] <= seg[j][REG_NUM-1];
         end
         ring.x <= x_in;
      end
   end

   // strobes one edge after the accepted X word
   always_ff @(posedge clk) begin
      if (rst) begin
         ring.step  <= 1'b0;
         ring.first <= 1'b0;
         ring.last  <= 1'b0;
      end else begin
         ring.step  <= rot_en;
         ring.first <= rot_en && (step_cnt == '0);
         ring.last  <= rot_en && pass_end;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         load_cnt <= '0;
         step_cnt <= '0;
         pass_cnt <= '0;
         busy     <= 1'b0;
      end else begin
         case (state)
            IDLE, LOAD: begin
               if (y_in_v) begin
                  busy <= 1'b1;
                  if (load_last) begin
                     load_cnt <= '0;
                     state    <= WAIT;
                  end else begin
                     load_cnt <= load_cnt + load_cnt_t'(1);
                     state    <= LOAD;
                  end
               end
            end
            WAIT, SHIFT: begin
               if (x_in_v) begin
                  if (pass_end) begin
                     step_cnt <= '0;
                     // final pass done, ring free for a new block
                     if (iter_end) begin
                        pass_cnt <= '0;
                        busy     <= 1'b0;
                        state    <= IDLE;
                     end else begin
                        pass_cnt <= pass_cnt + pass_cnt_t'(1);
                        state    <= WAIT;
                     end
                  end else begin
                     step_cnt <= step_cnt + step_cnt_t'(1);
                     state    <= SHIFT;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/pe_array.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array #(
   parameter int DATA_WIDTH = corr_data_pkg::DATA_WIDTH,
   parameter int PE_NUM     = 4,
   parameter int REG_NUM    = 8
) (
   input  logic clk,
   input  logic rst,
   ring_if.snk  ring,
   output logic [2*corr_data_pkg::acc_w(DATA_WIDTH, REG_NUM)-1:0] bank [PE_NUM],
   output logic bank_v
);
   import corr_data_pkg::*;

   localparam int PW = prod_w(DATA_WIDTH);
   localparam int AW = acc_w(DATA_WIDTH, REG_NUM);

   ////////////////////////////////////////////////////////////////////////////
   // MAC lanes
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < PE_NUM; i++) begin : g_lane
      // operands widened to product width, sign kept
      logic signed [PW-1:0] tr;
      logic signed [PW-1:0] ti;
      logic signed [PW-1:0] xr;
      logic signed [PW-1:0] xi;
      logic signed [PW-1:0] pr;
      logic signed [PW-1:0] pi;
      logic signed [AW-1:0] acc_re;
      logic signed [AW-1:0] acc_im;
      logic signed [AW-1:0] sum_re;
      logic signed [AW-1:0] sum_im;

      assign tr = PW'($signed(ring.tap[i][DATA_WIDTH +: DATA_WIDTH]));
      assign ti = PW'($signed(ring.tap[i][0 +: DATA_WIDTH]));
      assign xr = PW'($signed(ring.x[DATA_WIDTH +: DATA_WIDTH]));
      assign xi = PW'($signed(ring.x[0 +: DATA_WIDTH]));

      // (tr + j ti)(xr + j xi)
      assign pr = tr * xr - ti * xi;
      assign pi = tr * xi + ti * xr;

      // first step of a pass restarts the sum
      assign sum_re = ring.first ? AW'(pr) : acc_re + AW'(pr);
      assign sum_im = ring.first ? AW'(pi) : acc_im + AW'(pi);

      always_ff @(posedge clk) begin
         if (ring.step) begin
            acc_re <= sum_re;
            acc_im <= sum_im;
         end
      end

      // bank holds a finished pass while the next one accumulates
      always_ff @(posedge clk) begin
         if (ring.step && ring.last) begin
            bank[i] <= {sum_re, sum_im};
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // bank strobe
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         bank_v <= 1'b0;
      end else begin
         bank_v <= ring.step && ring.last;
      end
   end

endmodule

`default_nettype wire

// File: verilog/result_piso.sv
`timescale 1ns/10ps
`default_nettype none

module result_piso #(
   parameter int DATA_WIDTH = corr_data_pkg::DATA_WIDTH,
   parameter int PE_NUM     = 4,
   parameter int REG_NUM    = 8
) (
   input  logic clk,
   input  logic rst,
   input  logic [2*corr_data_pkg::acc_w(DATA_WIDTH, REG_NUM)-1:0] bank [PE_NUM],
   input  logic bank_v,
   output logic [2*corr_data_pkg::acc_w(DATA_WIDTH, REG_NUM)-1:0] res,
   output logic res_v
);
   import corr_data_pkg::*;

   localparam int CW = 2 * acc_w(DATA_WIDTH, REG_NUM);
   localparam int IW = (PE_NUM > 1) ? $clog2(PE_NUM) : 1;

   // copy of the bank, drained lane by lane
   logic [CW-1:0] hold [PE_NUM];
   // next lane to send
   logic [IW-1:0] idx;
   // lanes still pending after the current word
   logic          more;

   // lane 0 leaves straight from the bank, the rest from the copy
   always_ff @(posedge clk) begin
      if (bank_v) begin
         hold <= bank;
         res  <= bank[0];
      end else if (more) begin
         res  <= hold[idx];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         res_v <= 1'b0;
         idx   <= '0;
         more  <= 1'b0;
      end else if (bank_v) begin
         res_v <= 1'b1;
         idx   <= IW'(1);
         more  <= PE_NUM > 1;
      end else if (more) begin
         res_v <= 1'b1;
         idx   <= idx + IW'(1);
         more  <= idx != IW'(PE_NUM - 1);
      end else begin
         res_v <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/corr_top.sv
`timescale 1ns/10ps
`default_nettype none

module corr_top #(
   parameter int DATA_WIDTH = 8,
   parameter int PE_NUM     = 4,
   parameter int REG_NUM    = 8,
   parameter int ITER_NUM   = 4
) (
   input  logic                   clk,
   input  logic                   rst,
   input  corr_data_pkg::sample_t y_in,
   input  logic                   y_in_v,
   input  corr_data_pkg::sample_t x_in,
   input  logic                   x_in_v,
   output logic [2*corr_data_pkg::acc_w(DATA_WIDTH, REG_NUM)-1:0] res,
   output logic                   res_v,
   output logic                   busy
);
   import corr_data_pkg::*;

   localparam int CW = 2 * acc_w(DATA_WIDTH, REG_NUM);

   // finished pass, one word per lane
   logic [CW-1:0] bank [PE_NUM];
   logic          bank_v;

   ring_if #(.PE_NUM(PE_NUM)) ring ();

   // Y ring and step sequencer
   sipo_y #(
      .PE_NUM   (PE_NUM),
      .REG_NUM  (REG_NUM),
      .ITER_NUM (ITER_NUM)
   ) sipo_y_inst (
      .clk    (clk),
      .rst    (rst),
      .y_in   (y_in),
      .y_in_v (y_in_v),
      .x_in   (x_in),
      .x_in_v (x_in_v),
      .busy   (busy),
      .ring   (ring.src)
   );

   // complex MAC lanes
   pe_array #(
      .DATA_WIDTH (DATA_WIDTH),
      .PE_NUM     (PE_NUM),
      .REG_NUM    (REG_NUM)
   ) pe_array_inst (
      .clk    (clk),
      .rst    (rst),
      .ring   (ring.snk),
      .bank   (bank),
      .bank_v (bank_v)
   );

   // result serializer
   result_piso #(
      .DATA_WIDTH (DATA_WIDTH),
      .PE_NUM     (PE_NUM),
      .REG_NUM    (REG_NUM)
   ) result_piso_inst (
      .clk    (clk),
      .rst    (rst),
      .bank   (bank),
      .bank_v (bank_v),
      .res    (res),
      .res_v  (res_v)
   );

endmodule

`default_nettype wire

// File: bench/corr_chk.sv
`timescale 1ns/10ps
`default_nettype none

module corr_chk #(
   parameter int PE_NUM  = 4,
   parameter int REG_NUM = 8
) (
   input logic clk,
   input logic rst,
   // ring side, tied low where bound to the serializer
   input logic step,
   input logic first,
   input logic last,
   input logic ring_live,
   // result side, tied low where bound to the ring
   input logic res_v
);

   // failed assertions so far, read by the testbench summary
   int fails = 0;
   // consecutive res_v cycles seen so far
   int run_len = 0;

   always_ff @(posedge clk) begin
      if (rst || !res_v) begin
         run_len <= 0;
      end else begin
         run_len <= run_len + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output burst
   ////////////////////////////////////////////////////////////////////////////

   // never more than PE_NUM words in one burst
   res_burst_max: assert property (@(posedge clk) disable iff (rst)
      res_v |-> run_len < PE_NUM)
   else begin
      $error("res_v held longer than %0d cycles", PE_NUM);
      fails++;
   end

   // and never fewer
   res_burst_min: assert property (@(posedge clk) disable iff (rst)
      (!res_v && run_len != 0) |-> run_len == PE_NUM)
   else begin
      $error("res_v burst of %0d cycles, %0d wanted", run_len, PE_NUM);
      fails++;
   end

   ////////////////////////////////////////////////////////////////////////////
   // ring strobes
   ////////////////////////////////////////////////////////////////////////////

   // step comes one edge after an X word taken in WAIT or SHIFT
   step_state: assert property (@(posedge clk) disable iff (rst)
      step |-> $past(ring_live))
   else begin
      $error("step without an accepted X word");
      fails++;
   end

   first_step: assert property (@(posedge clk) disable iff (rst)
      first |-> step)
   else begin
      $error("first without step");
      fails++;
   end

   last_step: assert property (@(posedge clk) disable iff (rst)
      last |-> step)
   else begin
      $error("last without step");
      fails++;
   end

   // serializer must drain before the next pass ends
   ring_depth: assert property (@(posedge clk) REG_NUM >= PE_NUM)
   else begin
      $error("REG_NUM %0d below PE_NUM %0d", REG_NUM, PE_NUM);
      fails++;
   end

endmodule

bind sipo_y corr_chk #(
   .PE_NUM  (PE_NUM),
   .REG_NUM (REG_NUM)
) seq_chk (
   .clk       (clk),
   .rst       (rst),
   .step      (ring.step),
   .first     (ring.first),
   .last      (ring.last),
   .ring_live (state == corr_seq_pkg::WAIT || state == corr_seq_pkg::SHIFT),
   .res_v     (1'b0)
);

bind result_piso corr_chk #(
   .PE_NUM  (PE_NUM),
   .REG_NUM (REG_NUM)
) out_chk (
   .clk       (clk),
   .rst       (rst),
   .step      (1'b0),
   .first     (1'b0),
   .last      (1'b0),
   .ring_live (1'b0),
   .res_v     (res_v)
);

`default_nettype wire

// File: bench/tb_corr.sv
`timescale 1ns/10ps
`default_nettype none

module tb_corr;
   import corr_data_pkg::*;

   localparam int DW         = DATA_WIDTH;
   localparam int PE_NUM     = 4;
   localparam int REG_NUM    = 8;
   localparam int ITER_NUM   = 4;
   localparam int RING_LEN   = PE_NUM * REG_NUM;
   localparam int STEPS      = ITER_NUM * REG_NUM;
   localparam int AW         = acc_w(DW, REG_NUM);
   localparam int RW         = 2 * AW;
   localparam int CLK_PERIOD = 40;
   // seven Y/X blocks in all, eight clocks per word of slack
   localparam int WATCHDOG_CYCLES = 7 * (RING_LEN + STEPS) * 8;
   localparam logic [DW-1:0] MIN_V = {1'b1, {(DW-1){1'b0}}};
   localparam logic [DW-1:0] MAX_V = {1'b0, {(DW-1){1'b1}}};

   logic          clk;
   logic          rst;
   sample_t       y_in;
   logic          y_in_v;
   sample_t       x_in;
   logic          x_in_v;
   logic [RW-1:0] res;
   logic          res_v;
   logic          busy;

   // current Y block and X stream
   sample_t       y_blk [RING_LEN];
   sample_t       x_blk [STEPS];
   // expected result words, oldest first
   logic [RW-1:0] exp_q [$];
   logic [RW-1:0] exp_w;
   string         test_name;
   int            seed       = 72171;
   int            val_errs   = 0;
   int            other_errs = 0;
   int            chk_errs;

   corr_top #(
      .DATA_WIDTH (DW),
      .PE_NUM     (PE_NUM),
      .REG_NUM    (REG_NUM),
      .ITER_NUM   (ITER_NUM)
   ) corr_top_inst (
      .clk    (clk),
      .rst    (rst),
      .y_in   (y_in),
      .y_in_v (y_in_v),
      .x_in   (x_in),
      .x_in_v (x_in_v),
      .res    (res),
      .res_v  (res_v),
      .busy   (busy)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // lane result of pass p, lane taps w[((PE-1-lane)*REG + s) mod N]
   function automatic logic [RW-1:0] ref_word(input int p, input int lane);
      int re;
      int im;
      int idx;
      int tr;
      int ti;
      int xr;
      int xi;
      re = 0;
      im = 0;
      for (int s = p * REG_NUM; s < (p + 1) * REG_NUM; s++) begin
         idx = ((PE_NUM - 1 - lane) * REG_NUM + s) % RING_LEN;
         tr  = $signed(y_blk[idx][DW +: DW]);
         ti  = $signed(y_blk[idx][0 +: DW]);
         xr  = $signed(x_blk[s][DW +: DW]);
         xi  = $signed(x_blk[s][0 +: DW]);
         re  = re + tr * xr - ti * xi;
         im  = im + tr * xi + ti * xr;
      end
      return {AW'(re), AW'(im)};
   endfunction

   // whole block, pass by pass, lane 0 first
   task automatic push_expected();
      for (int p = 0; p < ITER_NUM; p++) begin
         for (int lane = 0; lane < PE_NUM; lane++) begin
            exp_q.push_back(ref_word(p, lane));
         end
      end
   endtask

   task automatic fill_random();
      for (int n = 0; n < RING_LEN; n++) begin
         y_blk[n] = sample_t'($random(seed));
      end
      for (int s = 0; s < STEPS; s++) begin
         x_blk[s] = sample_t'($random(seed));
      end
      // corner operands, MIN*MIN meets in the last lane at step 1
      y_blk[1]  = {MIN_V, MIN_V};
      x_blk[1]  = {MIN_V, MIN_V};
      y_blk[9]  = {MAX_V, MIN_V};
      x_blk[10] = {MIN_V, MAX_V};
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // drivers
   ////////////////////////////////////////////////////////////////////////////

   // rst from the calling edge on, seen by the DUT for cycles edges
   task automatic do_reset(input int cycles);
      rst    <= 1'b1;
      y_in_v <= 1'b0;
      x_in_v <= 1'b0;
      repeat (cycles) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic check_busy(input logic exp);
      assert (busy === exp) else begin
         $display("ERR %s: expected busy %0b, got %0b", test_name, exp, busy);
         val_errs++;
      end
   endtask

   // one Y word per clock, junk adds X words the ring must drop
   task automatic load_y(input bit junk);
      for (int n = 0; n < RING_LEN; n++) begin
         @(posedge clk);
         y_in   <= y_blk[n];
         y_in_v <= 1'b1;
         if (junk) begin
            x_in   <= sample_t'($random(seed));
            x_in_v <= 1'b1;
         end
      end
      @(posedge clk);
      y_in_v <= 1'b0;
      x_in_v <= 1'b0;
   endtask

   // X words with up to gap_max idle clocks before each
   // junk adds Y words while rotating
   task automatic stream_x(input int n_steps, input int gap_max, input bit junk,
                           input bit chk_busy);
      int gap;
      for (int s = 0; s < n_steps; s++) begin
         if (chk_busy) begin
            @(negedge clk);
            check_busy(1'b1);
         end
         gap = (gap_max > 0) ? int'($unsigned($random(seed)) % (gap_max + 1)) : 0;
         repeat (gap) begin
            @(posedge clk);
            x_in_v <= 1'b0;
            y_in_v <= 1'b0;
         end
         @(posedge clk);
         x_in   <= x_blk[s];
         x_in_v <= 1'b1;
         if (junk) begin
            y_in   <= sample_t'($random(seed));
            y_in_v <= 1'b1;
         end
      end
      @(posedge clk);
      x_in_v <= 1'b0;
      y_in_v <= 1'b0;
   endtask

   // last burst lands a few clocks after the final X word
   task automatic wait_results();
      int cnt;
      cnt = 0;
      while (exp_q.size() > 0 && cnt < 2 * PE_NUM + 8) begin
         @(negedge clk);
         cnt++;
      end
      assert (exp_q.size() == 0) else begin
         $display("%0d result words never arrived in test %s", exp_q.size(), test_name);
         other_errs++;
         exp_q.delete();
      end
   endtask

   task automatic run_block(input int gap_max);
      push_expected();
      load_y(1'b0);
      stream_x(STEPS, gap_max, 1'b0, 1'b0);
      wait_results();
   endtask

   // res sampled mid-cycle, in order against the queue
   initial begin
      forever begin
         @(negedge clk);
         if (res_v === 1'b1) begin
            assert (exp_q.size() > 0) else begin
               $display("result word with nothing expected in test %s", test_name);
               other_errs++;
            end
            if (exp_q.size() > 0) begin
               exp_w = exp_q.pop_front();
               assert (res === exp_w) else begin
                  $display("ERR %s: expected %h, got %h", test_name, exp_w, res);
                  val_errs++;
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   // X = 1 at the first step of each pass, result is the lane tap there
   task automatic test_impulse();
      test_name = "impulse";
      for (int n = 0; n < RING_LEN; n++) begin
         y_blk[n] = {DW'(n + 1), DW'(-(n + 1))};
      end
      for (int s = 0; s < STEPS; s++) begin
         if (s % REG_NUM == 0) begin
            x_blk[s] = {DW'(1), DW'(0)};
         end else begin
            x_blk[s] = '0;
         end
      end
      run_block(0);
   endtask

   task automatic test_random();
      test_name = "random";
      fill_random();
      run_block(0);
   endtask

   // same data as the random test
   task automatic test_gapped();
      test_name = "gapped";
      run_block(3);
   endtask

   task automatic test_ignored_inputs();
      test_name = "ignored_inputs";
      fill_random();
      push_expected();
      @(negedge clk);
      check_busy(1'b0);
      load_y(1'b1);
      @(negedge clk);
      check_busy(1'b1);
      stream_x(STEPS, 1, 1'b1, 1'b1);
      @(negedge clk);
      check_busy(1'b0);
      wait_results();
      // second block on the same engine
      fill_random();
      run_block(0);
   endtask

   task automatic test_reset_mid_pass();
      test_name = "reset_mid_pass";
      fill_random();
      load_y(1'b0);
      // pass 0 banked but not yet sent, pass 1 one step in
      stream_x(REG_NUM + 1, 0, 1'b0, 1'b0);
      do_reset(4);
      repeat (2 * PE_NUM + 4) begin
         @(negedge clk);
         assert (res_v === 1'b0 && busy === 1'b0) else begin
            $display("ERR %s: expected res_v 0 busy 0, got res_v %0b busy %0b",
                     test_name, res_v, busy);
            val_errs++;
         end
      end
      fill_random();
      run_block(0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst       = 1'b1;
      y_in      = '0;
      y_in_v    = 1'b0;
      x_in      = '0;
      x_in_v    = 1'b0;
      test_name = "reset";
      do_reset(4);
      test_impulse();
      test_random();
      test_gapped();
      test_ignored_inputs();
      test_reset_mid_pass();
      repeat (4) @(posedge clk);
      chk_errs = corr_top_inst.sipo_y_inst.seq_chk.fails
               + corr_top_inst.result_piso_inst.out_chk.fails;
      $display("errors: %0d value, %0d other, %0d assertion",
               val_errs, other_errs, chk_errs);
      if (val_errs == 0 && other_errs == 0 && chk_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d clocks, run stalled", WATCHDOG_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
verilog/corr_data_pkg.sv
verilog/corr_seq_pkg.sv
verilog/ring_if.sv
verilog/sipo_y.sv
verilog/pe_array.sv
verilog/result_piso.sv
verilog/corr_top.sv
bench/corr_chk.sv
bench/tb_corr.sv

// File: Makefile
# Verilator flow for the block-circulant correlator
# any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= tb_corr
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= TESTBENCH PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# output stays on the terminal, the pass line sets the exit status
sim: build
	./$(SIM_BIN) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
